// File: Bender.yml
package:
  name: lenet_mac

sources:
  - files:
      - design/lenet_mac_pkg.sv
      - design/approx_mult_8x8.sv
      - design/mult_stage.sv
      - design/accum_stage.sv
      - design/lenet_mac_top.sv
  - target: simulation
    files:
      - bench/lenet_mac_model.sv
      - bench/lenet_mac_tb.sv

// File: bench/lenet_mac_model.sv
package lenet_mac_model;

    ////////////////////////////////////////////////////////////
    // reference product
    ////////////////////////////////////////////////////////////

    // rows seven and eight are exact and rows one to six go
    // through the fixed table of pairwise terms
    function automatic int approx_product(input logic [7:0] x, input logic [7:0] y);
        logic pp [8:1][7:0];
        int   sum;
        int   r;
        int   j;
        for (r = 1; r <= 8; r++) begin
            for (j = 0; j <= 7; j++) begin
                pp[r][j] = x[r-1] & y[j];
            end
        end
        sum = 0;
        if (x[6]) begin
            sum += int'(y) << 6;
        end
        if (x[7]) begin
            sum += int'(y) << 7;
        end
        // first correction word
        sum += int'(pp[3][1] ^ pp[4][0]) << 4;
        sum += int'(pp[1][4] | pp[2][3]) << 5;
        sum += int'(pp[1][5] | pp[2][4]) << 6;
        sum += int'(pp[1][7] | pp[2][6]) << 7;
        sum += int'(pp[2][7]) << 8;
        sum += int'(pp[3][6] & pp[4][5]) << 9;
        sum += int'(pp[4][7]) << 10;
        sum += int'(pp[5][7] ^ pp[6][6]) << 11;
        sum += int'(pp[5][7] & pp[6][6]) << 12;
        // second
        sum += int'(pp[1][6] & pp[2][5]) << 6;
        sum += int'(pp[3][4] ^ pp[4][3]) << 7;
        sum += int'(pp[3][6] ^ pp[4][5]) << 8;
        sum += int'(pp[3][7] | pp[4][6]) << 9;
        sum += int'(pp[5][6] & pp[6][5]) << 10;
        sum += int'(pp[6][7]) << 12;
        // third
        sum += int'(pp[3][4] & pp[4][3]) << 6;
        sum += int'(pp[3][5] & pp[4][4]) << 7;
        sum += int'(pp[5][3] | pp[6][2]) << 8;
        sum += int'(pp[5][5] & pp[6][4]) << 9;
        sum += int'(pp[5][6] | pp[6][5]) << 10;
        // fourth
        sum += int'(pp[3][5] | pp[4][4]) << 7;
        sum += int'(pp[5][4] | pp[6][3]) << 8;
        sum += int'(pp[5][5] | pp[6][4]) << 9;
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////
    // window result
    ////////////////////////////////////////////////////////////

    function automatic int window_result(input longint window_sum);
        longint shifted;
        shifted = window_sum >> lenet_mac_pkg::ACC_SHIFT;
        if (shifted > 255) begin
            return 255;
        end else begin
            return int'(shifted);
        end
    endfunction

endpackage

// File: bench/lenet_mac_tb.sv
module lenet_mac_tb;

    // idle is the gap before the next row
    typedef struct packed {
        logic [7:0] pixel;
        logic [7:0] weight;
        logic       last;
        logic [3:0] idle;
    } stim_row_t;

    logic                             clk;
    logic                             reset;
    logic                             in_strobe;
    lenet_mac_pkg::mac_in_t           in_item;
    logic                             out_strobe;
    logic [lenet_mac_pkg::DATA_W-1:0] out_result;

    stim_row_t stim_table[$];
    int        exp_result_q[$];
    int        exp_cycle_q[$];
    int        cycle_count = 0;
    int        cycle_limit = 0;
    int        seed = 37597;

    lenet_mac_top lenet_mac_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_strobe  (in_strobe),
        .in_item    (in_item),
        .out_strobe (out_strobe),
        .out_result (out_result)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%h got 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic add_row(input logic [7:0] pixel, input logic [7:0] weight,
                           input logic last, input logic [3:0] idle);
        stim_row_t row;
        row.pixel  = pixel;
        row.weight = weight;
        row.last   = last;
        row.idle   = idle;
        stim_table.push_back(row);
    endtask

    // windows of 1 to 25 items with gaps of 0 to 3 cycles
    task automatic add_random_windows(input int count);
        int          w;
        int          i;
        int          len;
        logic [31:0] rnd_pixel;
        logic [31:0] rnd_weight;
        logic [31:0] rnd_idle;
        for (w = 0; w < count; w++) begin
            len = 1 + ($unsigned($random(seed)) % 25);
            for (i = 0; i < len; i++) begin
                rnd_pixel  = $random(seed);
                rnd_weight = $random(seed);
                rnd_idle   = $random(seed);
                add_row(rnd_pixel[7:0], rnd_weight[7:0], i == len - 1,
                        {2'b00, rnd_idle[1:0]});
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cycle counter and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            stop_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // result monitor
    ////////////////////////////////////////////////////////////

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (out_strobe === 1'b1) begin
                if (exp_result_q.size() == 0) begin
                    $display("out_strobe went high with no window outstanding");
                    stop_run();
                end else begin
                    check_value("out_result", exp_result_q.pop_front(), out_result);
                    check_value("out_strobe cycle", exp_cycle_q.pop_front(), cycle_count);
                end
            end else if (out_strobe !== 1'b0) begin
                $display("out_strobe is unknown after reset");
                stop_run();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin : run_tests
        longint    win_sum;
        stim_row_t row;
        int        idle_total;
        int        i;
        int        drain;

        reset     = 1'b1;
        in_strobe = 1'b0;
        in_item   = '0;

        // zero operands
        add_row(8'd0, 8'd200, 1'b0, 4'd2);
        add_row(8'd150, 8'd0, 1'b0, 4'd1);
        add_row(8'd0, 8'd0, 1'b1, 4'd3);
        // pixels on bits 6 and 7 only, exact
        add_row(8'hc0, 8'hff, 1'b0, 4'd0);
        add_row(8'h40, 8'h7b, 1'b0, 4'd1);
        add_row(8'h80, 8'h11, 1'b1, 4'd0);
        add_row(8'h80, 8'h80, 1'b1, 4'd2);
        // single-item windows back to back
        add_row(8'd200, 8'd100, 1'b1, 4'd0);
        add_row(8'd17, 8'd250, 1'b1, 4'd0);
        add_row(8'd255, 8'd255, 1'b1, 4'd0);
        add_row(8'd3, 8'd5, 1'b1, 4'd1);
        // full scale, saturates
        for (i = 0; i < 4; i++) begin
            add_row(8'hff, 8'hff, i == 3, 4'd0);
        end
        for (i = 0; i < 9; i++) begin
            add_row(8'hff, 8'hfe, i == 8, 4'd1);
        end
        add_random_windows(12);

        idle_total = 0;
        foreach (stim_table[k]) begin
            idle_total += stim_table[k].idle;
        end
        cycle_limit = stim_table.size() + idle_total + 20;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        win_sum = 0;
        for (i = 0; i < stim_table.size(); i++) begin
            row = stim_table[i];
            in_strobe      = 1'b1;
            in_item.pixel  = row.pixel;
            in_item.weight = row.weight;
            in_item.last   = row.last;
            if (row.pixel[5:0] == 6'd0) begin
                // only the exact rows seven and eight take part
                win_sum += int'(row.pixel) * int'(row.weight);
            end else begin
                win_sum += lenet_mac_model::approx_product(row.pixel, row.weight);
            end
            if (row.last) begin
                exp_result_q.push_back(lenet_mac_model::window_result(win_sum));
                // product at the next edge and result one edge later
                exp_cycle_q.push_back(cycle_count + 2);
                win_sum = 0;
            end
            @(posedge clk);
            #1;
            in_strobe = 1'b0;
            repeat (row.idle) begin
                @(posedge clk);
                #1;
            end
        end

        // let the last results come out and then watch for strays
        for (drain = 0; drain < 6 && exp_result_q.size() != 0; drain++) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        if (exp_result_q.size() != 0) begin
            $display("%0d window results never came out", exp_result_q.size());
            stop_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: design/accum_stage.sv
module accum_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             prod_strobe,
    input  lenet_mac_pkg::prod_t             prod_item,
    output logic                             out_strobe,
    output logic [lenet_mac_pkg::DATA_W-1:0] out_result
);

    // running window sum
    logic [lenet_mac_pkg::ACC_W-1:0] acc_sum;

    // sum including the product arriving now
    logic [lenet_mac_pkg::ACC_W-1:0] sum_next;

    // scaled sum before the clip
    logic [lenet_mac_pkg::ACC_W-1:0] sum_shifted;

    // clipped result for the closing item
    logic [lenet_mac_pkg::DATA_W-1:0] result_sat;

    // window closes on this cycle
    logic window_done;

    ////////////////////////////////////////////////////////////
    // sum and result shaping
    ////////////////////////////////////////////////////////////

    always_comb begin
        sum_next = acc_sum
                 + {{(lenet_mac_pkg::ACC_W - lenet_mac_pkg::PROD_W){1'b0}},
                    prod_item.product};
    end

    always_comb begin
        sum_shifted = sum_next >> lenet_mac_pkg::ACC_SHIFT;
    end

    // any bit above the result width means overflow
    always_comb begin
        if (|sum_shifted[lenet_mac_pkg::ACC_W-1:lenet_mac_pkg::DATA_W]) begin
            result_sat = {lenet_mac_pkg::DATA_W{1'b1}};
        end else begin
            result_sat = sum_shifted[lenet_mac_pkg::DATA_W-1:0];
        end
    end

    assign window_done = prod_strobe & prod_item.last;

    ////////////////////////////////////////////////////////////
    // accumulator
    ////////////////////////////////////////////////////////////

    // restarts from zero on the closing item, so the next
    // window can start in the following cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_sum <= '0;
        end else if (window_done) begin
            acc_sum <= '0;
        end else if (prod_strobe) begin
            acc_sum <= sum_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // result output
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= window_done;
        end
    end

    // held until the next window closes
    always_ff @(posedge clk) begin
        if (window_done) begin
            out_result <= result_sat;
        end
    end

endmodule

// File: design/approx_mult_8x8.sv
module approx_mult_8x8 (
    input  logic [lenet_mac_pkg::DATA_W-1:0] x,
    input  logic [lenet_mac_pkg::DATA_W-1:0] y,
    output logic [lenet_mac_pkg::PROD_W-1:0] z
);

    // partial product row i is y gated by x[i-1]
    logic [8:1][lenet_mac_pkg::DATA_W-1:0] row;

    // compressed terms from rows one to six
    logic [12:0] corr1;
    logic [12:0] corr2;
    logic [12:0] corr3;
    logic [12:0] corr4;

    // all addends widened to the product
    logic [lenet_mac_pkg::PROD_W-1:0] row7_term;
    logic [lenet_mac_pkg::PROD_W-1:0] row8_term;

    ////////////////////////////////////////////////////////////
    // partial products
    ////////////////////////////////////////////////////////////

    for (genvar i = 1; i <= 8; i++) begin : gen_rows
        assign row[i] = y & {lenet_mac_pkg::DATA_W{x[i-1]}};
    end

    ////////////////////////////////////////////////////////////
    // approximate compression of rows one to six
    ////////////////////////////////////////////////////////////

    // unlisted bit positions stay at zero
    always_comb begin
        corr1     = '0;
        corr1[4]  = row[3][1] ^ row[4][0];
        corr1[5]  = row[1][4] | row[2][3];
        corr1[6]  = row[1][5] | row[2][4];
        corr1[7]  = row[1][7] | row[2][6];
        corr1[8]  = row[2][7];
        corr1[9]  = row[3][6] & row[4][5];
        corr1[10] = row[4][7];
        corr1[11] = row[5][7] ^ row[6][6];
        corr1[12] = row[5][7] & row[6][6];
    end

    always_comb begin
        corr2     = '0;
        corr2[6]  = row[1][6] & row[2][5];
        corr2[7]  = row[3][4] ^ row[4][3];
        corr2[8]  = row[3][6] ^ row[4][5];
        corr2[9]  = row[3][7] | row[4][6];
        corr2[10] = row[5][6] & row[6][5];
        corr2[12] = row[6][7];
    end

    always_comb begin
        corr3     = '0;
        corr3[6]  = row[3][4] & row[4][3];
        corr3[7]  = row[3][5] & row[4][4];
        corr3[8]  = row[5][3] | row[6][2];
        corr3[9]  = row[5][5] & row[6][4];
        corr3[10] = row[5][6] | row[6][5];
    end

    always_comb begin
        corr4    = '0;
        corr4[7] = row[3][5] | row[4][4];
        corr4[8] = row[5][4] | row[6][3];
        corr4[9] = row[5][5] | row[6][4];
    end

    ////////////////////////////////////////////////////////////
    // exact rows and final sum
    ////////////////////////////////////////////////////////////

    // rows seven and eight sit at weights 2^6 and 2^7
    assign row7_term = {2'b00, row[7], 6'b000000};
    assign row8_term = {1'b0, row[8], 7'b0000000};

    assign z = row7_term
             + row8_term
             + {3'b000, corr1}
             + {3'b000, corr2}
             + {3'b000, corr3}
             + {3'b000, corr4};

endmodule

// File: design/lenet_mac_pkg.sv
package lenet_mac_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // pixel, weight and result
    localparam int DATA_W = 8;

    // full product of two data words
    localparam int PROD_W = 2 * DATA_W;

    // more than 256 full-scale products fit without overflow
    localparam int ACC_W = 24;

    ////////////////////////////////////////////////////////////
    // result scaling
    ////////////////////////////////////////////////////////////

    // window sum is shifted right by this before the clip to 8 bits
    localparam int ACC_SHIFT = 8;

    ////////////////////////////////////////////////////////////
    // items
    ////////////////////////////////////////////////////////////

    // one pixel/weight pair from the window
    typedef struct packed {
        logic [DATA_W-1:0] pixel;
        logic [DATA_W-1:0] weight;
        logic              last;
    } mac_in_t;

    // approximate product tagged with the window end
    typedef struct packed {
        logic [PROD_W-1:0] product;
        logic              last;
    } prod_t;

endpackage

// File: design/lenet_mac_top.sv
module lenet_mac_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_strobe,
    input  lenet_mac_pkg::mac_in_t           in_item,
    output logic                             out_strobe,
    output logic [lenet_mac_pkg::DATA_W-1:0] out_result
);

    // multiply stage to accumulate stage
    logic                 prod_strobe;
    lenet_mac_pkg::prod_t prod_item;

    ////////////////////////////////////////////////////////////
    // producer
    ////////////////////////////////////////////////////////////

    mult_stage mult_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .in_strobe   (in_strobe),
        .in_item     (in_item),
        .prod_strobe (prod_strobe),
        .prod_item   (prod_item)
    );

    ////////////////////////////////////////////////////////////
    // consumer
    ////////////////////////////////////////////////////////////

    // one result per window two cycles after the last item
    accum_stage accum_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .prod_strobe (prod_strobe),
        .prod_item   (prod_item),
        .out_strobe  (out_strobe),
        .out_result  (out_result)
    );

endmodule

// File: design/mult_stage.sv
module mult_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_strobe,
    input  lenet_mac_pkg::mac_in_t in_item,
    output logic                   prod_strobe,
    output lenet_mac_pkg::prod_t   prod_item
);

    // combinational product of the current item
    logic [lenet_mac_pkg::PROD_W-1:0] product;

    ////////////////////////////////////////////////////////////
    // multiplier
    ////////////////////////////////////////////////////////////

    approx_mult_8x8 approx_mult_8x8_inst (
        .x (in_item.pixel),
        .y (in_item.weight),
        .z (product)
    );

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    // strobe follows the input one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_strobe <= 1'b0;
        end else begin
            prod_strobe <= in_strobe;
        end
    end

    // payload only loads on a valid item
    always_ff @(posedge clk) begin
        if (in_strobe) begin
            prod_item.product <= product;
            prod_item.last    <= in_item.last;
        end
    end

endmodule

// File: vlog.f
design/lenet_mac_pkg.sv
design/approx_mult_8x8.sv
design/mult_stage.sv
design/accum_stage.sv
design/lenet_mac_top.sv
bench/lenet_mac_model.sv
bench/lenet_mac_tb.sv
